/* rsa_bus_pkg.sv */
package rsa_bus_pkg;

    // register block offsets, byte addressed.
    localparam int addr_w      = 5;
    localparam int rx_base     = 0;
    localparam int tx_base     = 4;
    localparam int status_base = 8;

    // status register flags.
    localparam int tx_ok_bit = 6;
    localparam int rx_ok_bit = 7;

    // bus controller states.
    typedef enum logic [2:0] {
        poll_rx,
        read_rx,
        wait_core,
        poll_tx,
        write_tx
    } bus_state_t;

endpackage

/* rsa_math_pkg.sv */
package rsa_math_pkg;

    localparam int key_w      = 256;
    localparam int key_bytes  = 32;
    localparam int out_bytes  = 31;  // top byte of the result is never sent.
    localparam int load_bytes = 96;  // n, d and one ciphertext block.

    // exponentiation core states.
    typedef enum logic [2:0] {
        idle,
        prep,
        step,
        final_mul,
        done
    } core_state_t;

endpackage

/* rsa_mod_prep.sv */
`timescale 1ns/1ps

module rsa_mod_prep (
    input  logic                           avm_clk,
    input  logic                           avm_rst,
    input  logic                           prep_start,
    input  logic [rsa_math_pkg::key_w-1:0] a,
    input  logic [rsa_math_pkg::key_w-1:0] n,
    output logic [rsa_math_pkg::key_w-1:0] t,
    output logic                           prep_done
);
    import rsa_math_pkg::*;

    logic [key_w-1:0] r;
    logic [key_w:0]   dbl;
    logic [key_w:0]   red;
    logic [7:0]       cnt;
    logic             busy;

    assign dbl = {r, 1'b0};
    assign red = dbl - {1'b0, n};
    assign t   = r;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy      <= 1'b0;
            cnt       <= 8'd0;
            prep_done <= 1'b0;
        end else begin
            prep_done <= 1'b0;
            if (prep_start) begin
                busy <= 1'b1;
                cnt  <= 8'd0;
            end else if (busy) begin
                cnt <= cnt + 8'd1;
                if (cnt == 8'(key_w - 1)) begin
                    busy      <= 1'b0;
                    prep_done <= 1'b1;
                end
            end
        end
    end

    // r < n, so one subtraction per doubling is enough.
    always_ff @(posedge avm_clk) begin
        if (prep_start) begin
            r <= a;
        end else if (busy) begin
            r <= (dbl >= {1'b0, n}) ? red[key_w-1:0] : dbl[key_w-1:0];
        end
    end

endmodule

/* rsa_mont_mul.sv */
`timescale 1ns/1ps

module rsa_mont_mul (
    input  logic                           avm_clk,
    input  logic                           avm_rst,
    input  logic                           mul_start,
    input  logic [rsa_math_pkg::key_w-1:0] a,
    input  logic [rsa_math_pkg::key_w-1:0] b,
    input  logic [rsa_math_pkg::key_w-1:0] n,
    output logic [rsa_math_pkg::key_w-1:0] p,
    output logic                           mul_done
);
    import rsa_math_pkg::*;

    logic [key_w-1:0] a_r;
    logic [key_w+1:0] acc;     // stays below 2n.
    logic [key_w+1:0] sum_ab;
    logic [key_w+1:0] sum_n;
    logic [key_w+1:0] diff;
    logic [7:0]       cnt;
    logic             busy;
    logic             fin;

    assign sum_ab = acc + (a_r[0] ? {2'b00, b} : '0);
    assign sum_n  = sum_ab[0] ? sum_ab + {2'b00, n} : sum_ab;  // make it even.
    assign diff   = acc - {2'b00, n};

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy     <= 1'b0;
            fin      <= 1'b0;
            cnt      <= 8'd0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= 1'b0;
            if (mul_start) begin
                busy <= 1'b1;
                cnt  <= 8'd0;
            end else if (busy) begin
                cnt <= cnt + 8'd1;
                if (cnt == 8'(key_w - 1)) begin
                    busy <= 1'b0;
                    fin  <= 1'b1;
                end
            end else if (fin) begin
                fin      <= 1'b0;
                mul_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (mul_start) begin
            a_r <= a;
            acc <= '0;
        end else if (busy) begin
            a_r <= a_r >> 1;
            acc <= {1'b0, sum_n[key_w+1:1]};
        end else if (fin) begin
            p <= (acc >= {2'b00, n}) ? diff[key_w-1:0] : acc[key_w-1:0];
        end
    end

endmodule

/* rsa256_core.sv */
`timescale 1ns/1ps

module rsa256_core (
    input  logic                           avm_clk,
    input  logic                           avm_rst,
    input  logic                           start,
    input  logic [rsa_math_pkg::key_w-1:0] n,
    input  logic [rsa_math_pkg::key_w-1:0] d,
    input  logic [rsa_math_pkg::key_w-1:0] enc,
    output logic [rsa_math_pkg::key_w-1:0] result,
    output logic                           done
);
    import rsa_math_pkg::*;

    core_state_t      state;
    logic [key_w-1:0] m_r;     // plain form.
    logic [key_w-1:0] t_r;     // montgomery form of enc^(2^i).
    logic [key_w-1:0] e_r;
    logic [key_w-1:0] prep_t;
    logic [key_w-1:0] m_p;
    logic [key_w-1:0] t_p;
    logic             prep_start;
    logic             prep_done;
    logic             mul_m_start;
    logic             mul_t_start;
    logic             mul_m_done;
    logic             mul_t_done;
    logic             m_ok;
    logic             t_ok;
    logic [7:0]       bit_cnt;
    logic             step_ok;

    rsa_mod_prep prep0 (
        .avm_clk   (avm_clk),
        .avm_rst   (avm_rst),
        .prep_start(prep_start),
        .a         (enc),
        .n         (n),
        .t         (prep_t),
        .prep_done (prep_done)
    );

    rsa_mont_mul mul_m (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .mul_start(mul_m_start),
        .a        (m_r),
        .b        (t_r),
        .n        (n),
        .p        (m_p),
        .mul_done (mul_m_done)
    );

    rsa_mont_mul mul_t (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .mul_start(mul_t_start),
        .a        (t_r),
        .b        (t_r),
        .n        (n),
        .p        (t_p),
        .mul_done (mul_t_done)
    );

    assign step_ok = (state == step) && (m_ok || mul_m_done) && (t_ok || mul_t_done);
    assign done    = (state == rsa_math_pkg::done);

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state       <= idle;
            prep_start  <= 1'b0;
            mul_m_start <= 1'b0;
            mul_t_start <= 1'b0;
            m_ok        <= 1'b0;
            t_ok        <= 1'b0;
            bit_cnt     <= 8'd0;
        end else begin
            prep_start  <= 1'b0;
            mul_m_start <= 1'b0;
            mul_t_start <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        prep_start <= 1'b1;
                        state      <= prep;
                    end
                end
                prep: begin
                    if (prep_done) begin
                        mul_t_start <= 1'b1;
                        mul_m_start <= e_r[0];
                        m_ok        <= !e_r[0];  // nothing to wait for.
                        t_ok        <= 1'b0;
                        bit_cnt     <= 8'd0;
                        state       <= step;
                    end
                end
                step: begin
                    if (mul_m_done) m_ok <= 1'b1;
                    if (mul_t_done) t_ok <= 1'b1;
                    if (step_ok) begin
                        if (bit_cnt == 8'(key_w - 1)) begin
                            state <= final_mul;
                        end else begin
                            bit_cnt     <= bit_cnt + 8'd1;
                            mul_t_start <= 1'b1;
                            mul_m_start <= e_r[1];  // next bit, e_r shifts this edge.
                            m_ok        <= !e_r[1];
                            t_ok        <= 1'b0;
                        end
                    end
                end
                final_mul: begin
                    state <= rsa_math_pkg::done;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state == idle && start) begin
            e_r <= d;
            m_r <= key_w'(1);
        end
        if (state == prep && prep_done) t_r <= prep_t;
        if (step_ok) begin
            t_r <= t_p;
            if (e_r[0]) m_r <= m_p;
            e_r <= e_r >> 1;
        end
        if (state == final_mul) result <= (m_r >= n) ? m_r - n : m_r;
    end

endmodule

/* rsa_key_regs.sv */
`timescale 1ns/1ps

module rsa_key_regs (
    input  logic                           avm_clk,
    input  logic                           avm_rst,
    input  logic [7:0]                     rx_byte,
    input  logic                           shift_n,
    input  logic                           shift_d,
    input  logic                           shift_enc,
    input  logic                           shift_out,
    input  logic                           load_out,
    input  logic [rsa_math_pkg::key_w-1:0] result,
    output logic [rsa_math_pkg::key_w-1:0] n,
    output logic [rsa_math_pkg::key_w-1:0] d,
    output logic [rsa_math_pkg::key_w-1:0] enc,
    output logic [7:0]                     tx_byte
);
    import rsa_math_pkg::*;

    logic [key_w-1:0] out_r;

    // msb first, so new bytes enter at the bottom.
    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            n     <= '0;
            d     <= '0;
            enc   <= '0;
            out_r <= '0;
        end else begin
            if (shift_n) n <= {n[key_w-9:0], rx_byte};
            if (shift_d) d <= {d[key_w-9:0], rx_byte};
            if (shift_enc) enc <= {enc[key_w-9:0], rx_byte};
            if (load_out) begin
                out_r <= result;
            end else if (shift_out) begin
                out_r <= {out_r[key_w-9:0], 8'd0};
            end
        end
    end

    assign tx_byte = out_r[key_w-9 -: 8];  // skips the top byte.

endmodule

/* rsa_bus_ctrl.sv */
`timescale 1ns/1ps

module rsa_bus_ctrl (
    input  logic                           avm_clk,
    input  logic                           avm_rst,
    output logic [rsa_bus_pkg::addr_w-1:0] address,
    output logic                           read,
    input  logic [31:0]                    readdata,
    output logic                           write,
    output logic [31:0]                    writedata,
    input  logic                           waitrequest,
    input  logic [7:0]                     tx_byte,
    output logic                           shift_n,
    output logic                           shift_d,
    output logic                           shift_enc,
    output logic                           shift_out,
    output logic                           load_out,
    output logic                           start,
    input  logic                           done
);
    import rsa_bus_pkg::*;
    import rsa_math_pkg::*;

    bus_state_t state;
    logic [6:0] byte_cnt;
    logic       rd_ok;
    logic       wr_ok;

    assign rd_ok = read && !waitrequest;   // read completes this edge.
    assign wr_ok = write && !waitrequest;

    // counter range picks the target register.
    always_comb begin
        shift_n   = 1'b0;
        shift_d   = 1'b0;
        shift_enc = 1'b0;
        if (state == read_rx && rd_ok) begin
            if (byte_cnt >= 7'(2 * key_bytes)) begin
                shift_n = 1'b1;
            end else if (byte_cnt >= 7'(key_bytes)) begin
                shift_d = 1'b1;
            end else begin
                shift_enc = 1'b1;
            end
        end
    end

    assign shift_out = (state == write_tx) && wr_ok;
    assign load_out  = (state == wait_core) && done;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state     <= poll_rx;
            byte_cnt  <= 7'(load_bytes - 1);
            address   <= addr_w'(status_base);
            read      <= 1'b1;
            write     <= 1'b0;
            writedata <= '0;
            start     <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                poll_rx: begin
                    if (rd_ok && readdata[rx_ok_bit]) begin
                        address <= addr_w'(rx_base);
                        state   <= read_rx;
                    end
                end
                read_rx: begin
                    if (rd_ok) begin
                        if (byte_cnt == 7'd0) begin
                            read     <= 1'b0;  // bus idle while computing.
                            start    <= 1'b1;
                            byte_cnt <= 7'(out_bytes - 1);
                            state    <= wait_core;
                        end else begin
                            byte_cnt <= byte_cnt - 7'd1;
                            address  <= addr_w'(status_base);
                            state    <= poll_rx;
                        end
                    end
                end
                wait_core: begin
                    if (done) begin
                        read    <= 1'b1;
                        address <= addr_w'(status_base);
                        state   <= poll_tx;
                    end
                end
                poll_tx: begin
                    if (rd_ok && readdata[tx_ok_bit]) begin
                        read      <= 1'b0;
                        write     <= 1'b1;
                        address   <= addr_w'(tx_base);
                        writedata <= {24'd0, tx_byte};
                        state     <= write_tx;
                    end
                end
                write_tx: begin
                    if (wr_ok) begin
                        write   <= 1'b0;
                        read    <= 1'b1;
                        address <= addr_w'(status_base);
                        if (byte_cnt == 7'd0) begin
                            byte_cnt <= 7'(key_bytes - 1);  // key kept, ciphertext only.
                            state    <= poll_rx;
                        end else begin
                            byte_cnt <= byte_cnt - 7'd1;
                            state    <= poll_tx;
                        end
                    end
                end
                default: begin
                    state <= poll_rx;
                end
            endcase
        end
    end

endmodule

/* rsa256_top.sv */
`timescale 1ns/1ps

module rsa256_top (
    input  logic                           avm_clk,
    input  logic                           avm_rst,
    output logic [rsa_bus_pkg::addr_w-1:0] avm_address,
    output logic                           avm_read,
    input  logic [31:0]                    avm_readdata,
    output logic                           avm_write,
    output logic [31:0]                    avm_writedata,
    input  logic                           avm_waitrequest
);
    import rsa_math_pkg::*;

    logic             shift_n;
    logic             shift_d;
    logic             shift_enc;
    logic             shift_out;
    logic             load_out;
    logic             start;
    logic             done;
    logic [7:0]       tx_byte;
    logic [key_w-1:0] n;
    logic [key_w-1:0] d;
    logic [key_w-1:0] enc;
    logic [key_w-1:0] result;

    rsa_bus_ctrl ctrl0 (
        .avm_clk    (avm_clk),
        .avm_rst    (avm_rst),
        .address    (avm_address),
        .read       (avm_read),
        .readdata   (avm_readdata),
        .write      (avm_write),
        .writedata  (avm_writedata),
        .waitrequest(avm_waitrequest),
        .tx_byte    (tx_byte),
        .shift_n    (shift_n),
        .shift_d    (shift_d),
        .shift_enc  (shift_enc),
        .shift_out  (shift_out),
        .load_out   (load_out),
        .start      (start),
        .done       (done)
    );

    rsa_key_regs regs0 (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .rx_byte  (avm_readdata[7:0]),  // rx data sits in the low byte.
        .shift_n  (shift_n),
        .shift_d  (shift_d),
        .shift_enc(shift_enc),
        .shift_out(shift_out),
        .load_out (load_out),
        .result   (result),
        .n        (n),
        .d        (d),
        .enc      (enc),
        .tx_byte  (tx_byte)
    );

    rsa256_core core0 (
        .avm_clk(avm_clk),
        .avm_rst(avm_rst),
        .start  (start),
        .n      (n),
        .d      (d),
        .enc    (enc),
        .result (result),
        .done   (done)
    );

endmodule

/* rsa256_checker.sv */
`timescale 1ns/1ps

module rsa256_checker (
    input  logic                           avm_clk,
    input  logic                           avm_rst,
    input  logic [rsa_bus_pkg::addr_w-1:0] avm_address,
    input  logic                           avm_read,
    input  logic                           avm_write,
    input  logic [31:0]                    avm_writedata,
    input  logic                           avm_waitrequest
);
    import rsa_bus_pkg::*;

    no_read_write: assert property (@(posedge avm_clk) disable iff (avm_rst)
        !(avm_read && avm_write))
        else $error("bus read and write are high in the same cycle");

    write_addr: assert property (@(posedge avm_clk) disable iff (avm_rst)
        avm_write |-> (avm_address == addr_w'(tx_base)))
        else $error("bus write to an address other than the transmit register");

    // only the data and status registers are ever read.
    read_addr: assert property (@(posedge avm_clk) disable iff (avm_rst)
        avm_read |-> (avm_address == addr_w'(rx_base) || avm_address == addr_w'(status_base)))
        else $error("bus read from an address other than receive or status");

    held_stable: assert property (@(posedge avm_clk) disable iff (avm_rst)
        (avm_read || avm_write) && avm_waitrequest |=>
            $stable(avm_address) && $stable(avm_read) && $stable(avm_write) &&
            $stable(avm_writedata))
        else $error("bus outputs changed while waitrequest was high");

    after_reset: assert property (@(posedge avm_clk)
        $fell(avm_rst) |-> (avm_read && !avm_write))
        else $error("bus is not polling status right after reset");

endmodule

bind rsa256_top rsa256_checker chk0 (
    .avm_clk        (avm_clk),
    .avm_rst        (avm_rst),
    .avm_address    (avm_address),
    .avm_read       (avm_read),
    .avm_write      (avm_write),
    .avm_writedata  (avm_writedata),
    .avm_waitrequest(avm_waitrequest)
);

/* tb_uart_model.sv */
`timescale 1ns/1ps

module tb_uart_model (
    input  logic                           avm_clk,
    input  logic                           avm_rst,
    input  logic [rsa_bus_pkg::addr_w-1:0] address,
    input  logic                           read,
    input  logic                           write,
    input  logic [31:0]                    writedata,
    output logic [31:0]                    readdata,
    output logic                           waitrequest,
    input  logic                           stall_en,
    input  logic                           rx_gap_en,
    input  logic                           tx_hold_en,
    input  logic                           rx_push,
    input  logic [7:0]                     rx_data,
    output logic                           tx_valid,
    output logic [7:0]                     tx_data,
    output logic                           fault,
    output int                             rx_level
);
    import rsa_bus_pkg::*;

    logic [7:0]  rx_q[$];
    int unsigned rx_gap;   // cycles until the next byte shows as ready.
    int unsigned tx_busy;
    logic        stall;

    initial begin
        readdata    = '0;
        waitrequest = 1'b0;
        tx_valid    = 1'b0;
        tx_data     = '0;
        fault       = 1'b0;
        rx_level    = 0;
        rx_gap      = 0;
        tx_busy     = 0;
        forever begin
            @(negedge avm_clk);
            tx_valid = 1'b0;
            fault    = 1'b0;
            if (rx_push) rx_q.push_back(rx_data);
            if (rx_gap != 0) rx_gap = rx_gap - 1;
            if (tx_busy != 0) tx_busy = tx_busy - 1;
            stall    = !avm_rst && stall_en && ($urandom % 3 == 0);
            readdata = '0;
            if (address == addr_w'(status_base)) begin
                readdata[rx_ok_bit] = (rx_q.size() != 0) && (rx_gap == 0);
                readdata[tx_ok_bit] = (tx_busy == 0);
            end else if (address == addr_w'(rx_base) && rx_q.size() != 0) begin
                readdata[7:0] = rx_q[0];
            end
            waitrequest = stall;
            // transfer completes on the next rising edge.
            if (!avm_rst && !stall && read && address == addr_w'(rx_base)) begin
                if (rx_q.size() == 0 || rx_gap != 0) begin
                    fault = 1'b1;  // read without rx_ok.
                end else begin
                    void'(rx_q.pop_front());
                    rx_gap = rx_gap_en ? $urandom % 24 : 0;
                end
            end
            if (!avm_rst && !stall && write && address == addr_w'(tx_base)) begin
                // upper data bits must be zero.
                fault    = fault || (tx_busy != 0) || (writedata[31:8] != 24'd0);
                tx_valid = 1'b1;
                tx_data  = writedata[7:0];
                tx_busy  = tx_hold_en ? $urandom % 40 : 0;
            end
            rx_level = rx_q.size();
        end
    end

endmodule

/* tb_rsa256.sv */
`timescale 1ns/1ps

module tb_rsa256;
    import rsa_bus_pkg::*;
    import rsa_math_pkg::*;

    localparam logic [31:0] rand_seed   = 32'h7eb8_cdba;
    localparam int          blk_timeout = 200000;

    logic              avm_clk = 1'b0;
    logic              avm_rst;
    logic [addr_w-1:0] avm_address;
    logic              avm_read;
    logic [31:0]       avm_readdata;
    logic              avm_write;
    logic [31:0]       avm_writedata;
    logic              avm_waitrequest;
    logic              stall_en;
    logic              rx_gap_en;
    logic              tx_hold_en;
    logic              rx_push;
    logic [7:0]        rx_data;
    logic              tx_valid;
    logic [7:0]        tx_data;
    logic              fault;
    int                rx_level;
    logic [255:0]      key_n;
    logic [255:0]      key_d;
    logic [247:0]      exp_val;
    string             exp_name;
    logic [247:0]      got;
    int                got_cnt     = 0;
    int                viol_cnt    = 0;
    int                blocks_done = 0;
    int                pass_cnt    = 0;
    int                fail_cnt    = 0;
    logic              timed_out   = 1'b0;

    always #20 avm_clk = ~avm_clk;

    rsa256_top dut0 (
        .avm_clk        (avm_clk),
        .avm_rst        (avm_rst),
        .avm_address    (avm_address),
        .avm_read       (avm_read),
        .avm_readdata   (avm_readdata),
        .avm_write      (avm_write),
        .avm_writedata  (avm_writedata),
        .avm_waitrequest(avm_waitrequest)
    );

    tb_uart_model uart0 (
        .avm_clk    (avm_clk),
        .avm_rst    (avm_rst),
        .address    (avm_address),
        .read       (avm_read),
        .write      (avm_write),
        .writedata  (avm_writedata),
        .readdata   (avm_readdata),
        .waitrequest(avm_waitrequest),
        .stall_en   (stall_en),
        .rx_gap_en  (rx_gap_en),
        .tx_hold_en (tx_hold_en),
        .rx_push    (rx_push),
        .rx_data    (rx_data),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data),
        .fault      (fault),
        .rx_level   (rx_level)
    );

    // square and multiply with full width products.
    function automatic logic [255:0] mod_exp(input logic [255:0] base, input logic [255:0] ex,
                                             input logic [255:0] md);
        logic [511:0] r;
        logic [511:0] b;
        logic [511:0] m;
        r = 512'd1;
        m = {256'd0, md};
        b = {256'd0, base} % m;
        for (int i = 0; i < 256; i++) begin
            if (ex[i]) r = (r * b) % m;
            b = (b * b) % m;
        end
        return r[255:0];
    endfunction

    function automatic logic [255:0] rand256();
        logic [255:0] v;
        for (int i = 0; i < 8; i++) begin
            v[i*32 +: 32] = $urandom;
        end
        return v;
    endfunction

    function automatic logic [255:0] rand_below_n();
        logic [255:0] v;
        v      = rand256();
        v[255] = 1'b0;  // n has its top bit set.
        return v;
    endfunction

    task automatic push_word(input logic [255:0] v);
        for (int i = 31; i >= 0; i--) begin
            @(posedge avm_clk);
            rx_push = 1'b1;
            rx_data = v[i*8 +: 8];
        end
        @(posedge avm_clk);
        rx_push = 1'b0;
    endtask

    task automatic set_knobs(input logic stall, input logic rx_gap, input logic tx_hold);
        @(posedge avm_clk);
        stall_en   = stall;
        rx_gap_en  = rx_gap;
        tx_hold_en = tx_hold;
    endtask

    task automatic reset_dut();
        @(negedge avm_clk);
        avm_rst = 1'b1;
        repeat (16) @(negedge avm_clk);
        avm_rst = 1'b0;
    endtask

    task automatic run_block(input string name, input logic [255:0] ctext, input bit with_key);
        logic [255:0] expect_full;
        int           target;
        int           cycles;
        if (timed_out) return;
        expect_full = mod_exp(ctext, key_d, key_n);
        exp_val     = expect_full[247:0];
        exp_name    = name;
        target      = blocks_done + 1;
        if (with_key) begin
            push_word(key_n);
            push_word(key_d);
        end
        push_word(ctext);
        cycles = 0;
        while (blocks_done < target && cycles < blk_timeout) begin
            @(posedge avm_clk);
            cycles++;
        end
        if (blocks_done < target) begin
            timed_out = 1'b1;
            fail_cnt  = fail_cnt + 1;
            $display("timeout: test %s got no complete result block", name);
        end
    endtask

    // collects each block of written bytes.
    always @(posedge avm_clk) begin
        if (fault) viol_cnt = viol_cnt + 1;
        if (tx_valid) begin
            got     = {got[239:0], tx_data};
            got_cnt = got_cnt + 1;
            if (got_cnt == out_bytes) begin
                assert (got == exp_val && viol_cnt == 0 && rx_level == 0) begin
                    pass_cnt = pass_cnt + 1;
                    $display("ok     %s", exp_name);
                end else begin
                    fail_cnt = fail_cnt + 1;
                    if (got != exp_val) begin
                        $display("FAILED %s expected %h actual %h", exp_name, exp_val, got);
                    end else begin
                        $display("%s: bad bus access or bytes left unread", exp_name);
                    end
                end
                viol_cnt    = 0;
                got_cnt     = 0;
                blocks_done = blocks_done + 1;
            end
        end
    end

    initial begin
        avm_rst    = 1'b1;
        stall_en   = 1'b0;
        rx_gap_en  = 1'b0;
        tx_hold_en = 1'b0;
        rx_push    = 1'b0;
        rx_data    = '0;
        void'($urandom(rand_seed));
        repeat (16) @(negedge avm_clk);
        avm_rst    = 1'b0;
        key_n      = rand256();
        key_n[255] = 1'b1;
        key_n[0]   = 1'b1;  // odd modulus.
        key_d      = rand256();
        run_block("basic_decrypt", rand_below_n(), 1'b1);
        for (int k = 0; k < 3; k++) begin
            run_block($sformatf("key_reuse_%0d", k), rand_below_n(), 1'b0);
        end
        run_block("enc_zero", '0, 1'b0);
        run_block("enc_one", 256'd1, 1'b0);
        set_knobs(1'b1, 1'b0, 1'b0);
        run_block("bus_stall", rand_below_n(), 1'b0);
        set_knobs(1'b0, 1'b0, 1'b1);
        run_block("tx_backpressure", rand_below_n(), 1'b0);
        set_knobs(1'b0, 1'b1, 1'b0);
        run_block("rx_starvation", rand_below_n(), 1'b0);
        set_knobs(1'b0, 1'b0, 1'b0);
        reset_dut();  // new key needs a full load.
        key_d = 256'd1;
        run_block("d_one", rand_below_n(), 1'b1);
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* rsa256.f */
rsa_bus_pkg.sv
rsa_math_pkg.sv
rsa_mod_prep.sv
rsa_mont_mul.sv
rsa256_core.sv
rsa_key_regs.sv
rsa_bus_ctrl.sv
rsa256_top.sv
rsa256_checker.sv
tb_uart_model.sv
tb_rsa256.sv

/* Makefile */
TOP = tb_rsa256

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f rsa256.f -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
